//--- logic/accel_cfg_pkg.sv
// array and layer configuration
package accel_cfg_pkg;

    localparam int ARRAY_DIM = 8;                  // rows and columns of the pe grid
    localparam int ACT_W     = 8;
    localparam int PSUM_W    = 16;                 // wraps modulo 2^16
    localparam int CHAN_W    = 8;
    localparam int DIM_CNT_W = $clog2(ARRAY_DIM) + 1;
    localparam int VEC_CNT_W = 5;                  // 1 to 16 vectors per layer

    typedef logic [ACT_W-1:0]     act_t;           // activation or weight
    typedef logic [PSUM_W-1:0]    psum_t;
    typedef logic [CHAN_W-1:0]    chan_t;          // real channel count
    typedef logic [CHAN_W+1:0]    span_t;          // channel count times three
    typedef logic [DIM_CNT_W-1:0] dim_cnt_t;       // clipped row or column count
    typedef logic [VEC_CNT_W-1:0] vec_cnt_t;
    typedef logic [VEC_CNT_W-2:0] vec_idx_t;       // vector number 0..15

    // codes 2 and 3 are reserved and handled like conv3x3
    typedef enum logic [1:0] {
        POINTWISE = 2'd0,
        CONV3X3   = 2'd1
    } layer_type_e;

    typedef enum logic [1:0] {
        IDLE        = 2'd0,
        PREHEAT     = 2'd1,
        NORMAL_LOOP = 2'd2,
        FINISH      = 2'd3
    } seq_state_e;

endpackage

//--- logic/accel_mem_pkg.sv
// global buffer layout
package accel_mem_pkg;

    localparam int GLB_DEPTH  = 64;
    localparam int GLB_ADDR_W = $clog2(GLB_DEPTH);
    localparam int LANE_W     = 16;                // one psum or act per lane
    localparam int GLB_WORD_W = accel_cfg_pkg::ARRAY_DIM * LANE_W;

    typedef logic [GLB_ADDR_W-1:0] glb_addr_t;
    typedef logic [GLB_WORD_W-1:0] glb_word_t;

    // word c holds column c weights, lane r for row r
    localparam glb_addr_t WEIGHT_BASE  = 6'd0;

    // word v holds input vector v, lane c for column c
    localparam glb_addr_t IFMAP_BASE   = 6'd8;

    localparam glb_addr_t SCRATCH_BASE = 6'd48;    // host side traffic only

endpackage

//--- logic/conv_core_top.sv
// convolution core top level
`timescale 1ns/1ns

module conv_core_top (
    input  logic                       clk,
    input  logic                       reset_i,
    input  logic                       host_wr_en_i,
    input  accel_mem_pkg::glb_addr_t   host_addr_i,
    input  accel_mem_pkg::glb_word_t   host_wdata_i,
    input  logic                       start_i,
    input  accel_cfg_pkg::layer_type_e layer_type_i,
    input  accel_cfg_pkg::chan_t       ic_real_i,
    input  accel_cfg_pkg::chan_t       oc_real_i,
    input  accel_cfg_pkg::vec_cnt_t    num_vectors_i,
    output logic                       busy_o,
    output logic                       done_o,
    output logic                       opsum_valid_o,
    output accel_cfg_pkg::vec_idx_t    opsum_index_o,
    output accel_mem_pkg::glb_word_t   opsum_data_o
);

    logic                     seq_rd_req;
    logic                     seq_rd_gnt;
    accel_mem_pkg::glb_addr_t seq_rd_addr;
    logic                     mem_en;
    logic                     mem_we;
    accel_mem_pkg::glb_addr_t mem_addr;
    accel_mem_pkg::glb_word_t mem_wdata;
    accel_mem_pkg::glb_word_t glb_rdata;
    logic                     preheat_state;
    logic                     normal_loop_state;
    logic [accel_cfg_pkg::ARRAY_DIM-1:0] ifmap_pop_matrix;
    logic                     pe_array_move;
    logic pe_advance_matrix [accel_cfg_pkg::ARRAY_DIM-1:0][accel_cfg_pkg::ARRAY_DIM-1:0];
    logic pe_en_matrix [accel_cfg_pkg::ARRAY_DIM-1:0][accel_cfg_pkg::ARRAY_DIM-1:0];
    // extra tap per row for the output
    accel_cfg_pkg::psum_t psum_chain [accel_cfg_pkg::ARRAY_DIM-1:0][accel_cfg_pkg::ARRAY_DIM:0];

    glb_arbiter i_glb_arbiter (
        .host_wr_en_i  (host_wr_en_i),
        .host_addr_i   (host_addr_i),
        .host_wdata_i  (host_wdata_i),
        .seq_rd_req_i  (seq_rd_req),
        .seq_rd_addr_i (seq_rd_addr),
        .seq_rd_gnt_o  (seq_rd_gnt),
        .mem_en_o      (mem_en),
        .mem_we_o      (mem_we),
        .mem_addr_o    (mem_addr),
        .mem_wdata_o   (mem_wdata)
    );

    glb_sram i_glb_sram (
        .clk     (clk),
        .en_i    (mem_en),
        .we_i    (mem_we),
        .addr_i  (mem_addr),
        .wdata_i (mem_wdata),
        .rdata_o (glb_rdata)
    );

    layer_sequencer i_layer_sequencer (
        .clk                 (clk),
        .reset_i             (reset_i),
        .start_i             (start_i),
        .num_vectors_i       (num_vectors_i),
        .seq_rd_gnt_i        (seq_rd_gnt),
        .seq_rd_req_o        (seq_rd_req),
        .seq_rd_addr_o       (seq_rd_addr),
        .preheat_state_o     (preheat_state),
        .normal_loop_state_o (normal_loop_state),
        .ifmap_pop_matrix_o  (ifmap_pop_matrix),
        .pe_array_move_o     (pe_array_move),
        .opsum_valid_o       (opsum_valid_o),
        .opsum_index_o       (opsum_index_o),
        .busy_o              (busy_o),
        .done_o              (done_o)
    );

    pe_array_controller i_pe_array_controller (
        .layer_type_i        (layer_type_i),
        .preheat_state_i     (preheat_state),
        .normal_loop_state_i (normal_loop_state),
        .ifmap_pop_matrix_i  (ifmap_pop_matrix),
        .pe_array_move_i     (pe_array_move),
        .ic_real_i           (ic_real_i),
        .oc_real_i           (oc_real_i),
        .pe_advance_matrix_o (pe_advance_matrix),
        .pe_en_matrix_o      (pe_en_matrix)
    );

    for (genvar r = 0; r < accel_cfg_pkg::ARRAY_DIM; r++) begin : g_row
        assign psum_chain[r][0] = '0;
        for (genvar c = 0; c < accel_cfg_pkg::ARRAY_DIM; c++) begin : g_col
            // weight comes from the row lane, activation from the column lane
            pe_cell i_pe_cell (
                .clk           (clk),
                .reset_i       (reset_i),
                .preheat_i     (preheat_state),
                .advance_i     (pe_advance_matrix[r][c]),
                .en_i          (pe_en_matrix[r][c]),
                .weight_lane_i (glb_rdata[r*accel_mem_pkg::LANE_W +: accel_cfg_pkg::ACT_W]),
                .act_lane_i    (glb_rdata[c*accel_mem_pkg::LANE_W +: accel_cfg_pkg::ACT_W]),
                .psum_i        (psum_chain[r][c]),
                .psum_o        (psum_chain[r][c+1])
            );
        end
        assign opsum_data_o[r*accel_mem_pkg::LANE_W +: accel_mem_pkg::LANE_W] =
            psum_chain[r][accel_cfg_pkg::ARRAY_DIM];
    end

endmodule

//--- logic/glb_arbiter.sv
// host first glb arbiter
`timescale 1ns/1ns

module glb_arbiter (
    input  logic                      host_wr_en_i,
    input  accel_mem_pkg::glb_addr_t  host_addr_i,
    input  accel_mem_pkg::glb_word_t  host_wdata_i,
    input  logic                      seq_rd_req_i,
    input  accel_mem_pkg::glb_addr_t  seq_rd_addr_i,
    output logic                      seq_rd_gnt_o,
    output logic                      mem_en_o,
    output logic                      mem_we_o,
    output accel_mem_pkg::glb_addr_t  mem_addr_o,
    output accel_mem_pkg::glb_word_t  mem_wdata_o
);

    always_comb begin
        seq_rd_gnt_o = 1'b0;
        mem_en_o     = 1'b0;
        mem_we_o     = 1'b0;
        mem_addr_o   = seq_rd_addr_i;
        mem_wdata_o  = host_wdata_i;

        if (host_wr_en_i) begin
            // host write always takes the port
            mem_en_o   = 1'b1;
            mem_we_o   = 1'b1;
            mem_addr_o = host_addr_i;
        end else if (seq_rd_req_i) begin
            seq_rd_gnt_o = 1'b1;
            mem_en_o     = 1'b1;
        end
    end

endmodule

//--- logic/glb_sram.sv
// single port global buffer
`timescale 1ns/1ns

module glb_sram (
    input  logic                      clk,
    input  logic                      en_i,
    input  logic                      we_i,
    input  accel_mem_pkg::glb_addr_t  addr_i,
    input  accel_mem_pkg::glb_word_t  wdata_i,
    output accel_mem_pkg::glb_word_t  rdata_o
);

    accel_mem_pkg::glb_word_t mem_q [accel_mem_pkg::GLB_DEPTH];

    always_ff @(posedge clk) begin
        if (en_i) begin
            if (we_i) begin
                mem_q[addr_i] <= wdata_i;
            end else begin
                rdata_o <= mem_q[addr_i];            // one cycle read latency
            end
        end
    end

endmodule

//--- logic/layer_sequencer.sv
// layer phase sequencer
`timescale 1ns/1ns

module layer_sequencer (
    input  logic                              clk,
    input  logic                              reset_i,
    input  logic                              start_i,
    input  accel_cfg_pkg::vec_cnt_t           num_vectors_i,
    input  logic                              seq_rd_gnt_i,
    output logic                              seq_rd_req_o,
    output accel_mem_pkg::glb_addr_t          seq_rd_addr_o,
    output logic                              preheat_state_o,
    output logic                              normal_loop_state_o,
    output logic [accel_cfg_pkg::ARRAY_DIM-1:0] ifmap_pop_matrix_o,
    output logic                              pe_array_move_o,
    output logic                              opsum_valid_o,
    output accel_cfg_pkg::vec_idx_t           opsum_index_o,
    output logic                              busy_o,
    output logic                              done_o
);

    accel_cfg_pkg::seq_state_e state_q;
    accel_cfg_pkg::seq_state_e state_d;
    accel_cfg_pkg::vec_cnt_t   issue_cnt_q;
    accel_cfg_pkg::vec_cnt_t   arrive_cnt_q;
    accel_cfg_pkg::vec_cnt_t   phase_len;
    accel_cfg_pkg::vec_idx_t   rd_tag_q;         // column or vector of the pending read
    logic                      rd_pend_q;
    logic                      rd_fire;
    logic                      last_arrive;

    assign preheat_state_o     = (state_q == accel_cfg_pkg::PREHEAT);
    assign normal_loop_state_o = (state_q == accel_cfg_pkg::NORMAL_LOOP);
    assign busy_o              = (state_q != accel_cfg_pkg::IDLE);

    // reads per phase: one weight word per column, then the vectors
    assign phase_len = preheat_state_o ?
                       accel_cfg_pkg::vec_cnt_t'(accel_cfg_pkg::ARRAY_DIM) : num_vectors_i;

    assign seq_rd_req_o  = (preheat_state_o || normal_loop_state_o) && (issue_cnt_q < phase_len);
    assign seq_rd_addr_o = (preheat_state_o ? accel_mem_pkg::WEIGHT_BASE :
                                              accel_mem_pkg::IFMAP_BASE) +
                           accel_mem_pkg::glb_addr_t'(issue_cnt_q);
    assign rd_fire       = seq_rd_req_o && seq_rd_gnt_i;
    assign last_arrive   = rd_pend_q && (arrive_cnt_q == phase_len - 1'b1);

    assign pe_array_move_o = normal_loop_state_o && rd_pend_q; // ifmap word on glb_rdata

    always_comb begin
        for (int c = 0; c < accel_cfg_pkg::ARRAY_DIM; c++) begin
            ifmap_pop_matrix_o[c] = preheat_state_o && rd_pend_q &&
                                    (rd_tag_q == accel_cfg_pkg::vec_idx_t'(c));
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            accel_cfg_pkg::IDLE: begin
                if (start_i) begin
                    state_d = accel_cfg_pkg::PREHEAT;
                end
            end
            accel_cfg_pkg::PREHEAT: begin
                if (last_arrive) begin
                    state_d = accel_cfg_pkg::NORMAL_LOOP; // all columns loaded
                end
            end
            accel_cfg_pkg::NORMAL_LOOP: begin
                if (last_arrive) begin
                    state_d = accel_cfg_pkg::FINISH;
                end
            end
            default: state_d = accel_cfg_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q       <= accel_cfg_pkg::IDLE;
            issue_cnt_q   <= '0;
            arrive_cnt_q  <= '0;
            rd_pend_q     <= 1'b0;
            opsum_valid_o <= 1'b0;
            done_o        <= 1'b0;
        end else begin
            state_q       <= state_d;
            rd_pend_q     <= rd_fire;            // data one cycle after the grant
            opsum_valid_o <= pe_array_move_o;
            done_o        <= (state_q == accel_cfg_pkg::FINISH);
            if (state_d != state_q) begin
                issue_cnt_q  <= '0;              // fresh count per phase
                arrive_cnt_q <= '0;
            end else begin
                if (rd_fire) begin
                    issue_cnt_q <= issue_cnt_q + 1'b1;
                end
                if (rd_pend_q) begin
                    arrive_cnt_q <= arrive_cnt_q + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_fire) begin
            rd_tag_q <= accel_cfg_pkg::vec_idx_t'(issue_cnt_q);
        end
        if (pe_array_move_o) begin
            opsum_index_o <= rd_tag_q;
        end
    end

endmodule

//--- logic/pe_array_controller.sv
// pe array advance and enable control
`timescale 1ns/1ns

module pe_array_controller (
    input  accel_cfg_pkg::layer_type_e layer_type_i,
    input  logic                       preheat_state_i,
    input  logic                       normal_loop_state_i,
    input  logic [accel_cfg_pkg::ARRAY_DIM-1:0] ifmap_pop_matrix_i,
    input  logic                       pe_array_move_i,
    input  accel_cfg_pkg::chan_t       ic_real_i,
    input  accel_cfg_pkg::chan_t       oc_real_i,
    output logic pe_advance_matrix_o [accel_cfg_pkg::ARRAY_DIM-1:0][accel_cfg_pkg::ARRAY_DIM-1:0],
    output logic pe_en_matrix_o [accel_cfg_pkg::ARRAY_DIM-1:0][accel_cfg_pkg::ARRAY_DIM-1:0]
);

    accel_cfg_pkg::span_t    row_raw;
    accel_cfg_pkg::span_t    col_raw;
    accel_cfg_pkg::dim_cnt_t row_num;
    accel_cfg_pkg::dim_cnt_t col_num;

    // advance source follows the phase
    always_comb begin
        for (int r = 0; r < accel_cfg_pkg::ARRAY_DIM; r++) begin
            for (int c = 0; c < accel_cfg_pkg::ARRAY_DIM; c++) begin
                if (preheat_state_i) begin
                    pe_advance_matrix_o[r][c] = ifmap_pop_matrix_i[c]; // weight load per column
                end else if (normal_loop_state_i) begin
                    pe_advance_matrix_o[r][c] = pe_array_move_i;
                end else begin
                    pe_advance_matrix_o[r][c] = 1'b0;
                end
            end
        end
    end

    always_comb begin
        if (layer_type_i == accel_cfg_pkg::POINTWISE) begin
            row_raw = accel_cfg_pkg::span_t'(oc_real_i);
            col_raw = accel_cfg_pkg::span_t'(ic_real_i);
        end else begin // 3x3 and reserved codes
            row_raw = accel_cfg_pkg::span_t'(oc_real_i) * accel_cfg_pkg::span_t'(3);
            col_raw = accel_cfg_pkg::span_t'(ic_real_i) * accel_cfg_pkg::span_t'(3);
        end

        // clip to the grid
        if (row_raw >= accel_cfg_pkg::span_t'(accel_cfg_pkg::ARRAY_DIM)) begin
            row_num = accel_cfg_pkg::dim_cnt_t'(accel_cfg_pkg::ARRAY_DIM);
        end else begin
            row_num = accel_cfg_pkg::dim_cnt_t'(row_raw);
        end
        if (col_raw >= accel_cfg_pkg::span_t'(accel_cfg_pkg::ARRAY_DIM)) begin
            col_num = accel_cfg_pkg::dim_cnt_t'(accel_cfg_pkg::ARRAY_DIM);
        end else begin
            col_num = accel_cfg_pkg::dim_cnt_t'(col_raw);
        end

        for (int r = 0; r < accel_cfg_pkg::ARRAY_DIM; r++) begin
            for (int c = 0; c < accel_cfg_pkg::ARRAY_DIM; c++) begin
                pe_en_matrix_o[r][c] = (accel_cfg_pkg::dim_cnt_t'(r) < row_num) &&
                                       (accel_cfg_pkg::dim_cnt_t'(c) < col_num);
            end
        end
    end

endmodule

//--- logic/pe_cell.sv
// multiply cell with chained row adder
`timescale 1ns/1ns

module pe_cell (
    input  logic                 clk,
    input  logic                 reset_i,
    input  logic                 preheat_i,      // advance loads weight, else product
    input  logic                 advance_i,
    input  logic                 en_i,
    input  accel_cfg_pkg::act_t  weight_lane_i,
    input  accel_cfg_pkg::act_t  act_lane_i,
    input  accel_cfg_pkg::psum_t psum_i,
    output accel_cfg_pkg::psum_t psum_o
);

    accel_cfg_pkg::act_t  weight_q;
    accel_cfg_pkg::psum_t product_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            weight_q  <= '0;
            product_q <= '0;
        end else if (advance_i) begin
            if (preheat_i) begin
                weight_q <= weight_lane_i;
            end else if (en_i) begin
                product_q <= accel_cfg_pkg::psum_t'(weight_q) *
                             accel_cfg_pkg::psum_t'(act_lane_i);
            end else begin
                product_q <= '0;                     // disabled cells add nothing
            end
        end
    end

    // row chain, column 0 toward column 7
    assign psum_o = psum_i + product_q;

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# builds and runs the convolution core simulation with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal -f sources.f --top-module conv_core_tb -o conv_core_sim

./obj_dir/conv_core_sim > sim.log
cat sim.log

if grep -q "all tests passed" sim.log; then
    exit 0
fi
echo "simulation reported a failure, see sim.log"
exit 1

//--- sources.f
logic/accel_cfg_pkg.sv
logic/accel_mem_pkg.sv
logic/pe_array_controller.sv
logic/pe_cell.sv
logic/glb_sram.sv
logic/glb_arbiter.sv
logic/layer_sequencer.sv
logic/conv_core_top.sv
testbench/conv_core_checker.sv
testbench/conv_core_tb.sv

//--- testbench/conv_core_checker.sv
// opsum and done checker
`timescale 1ns/1ns

module conv_core_checker (
    input  logic                     clk,
    input  logic                     reset_i,
    input  logic                     start_i,
    input  int                       rec_sel_i,
    input  logic                     busy_i,
    input  logic                     done_i,
    input  logic                     opsum_valid_i,
    input  accel_cfg_pkg::vec_idx_t  opsum_index_i,
    input  accel_mem_pkg::glb_word_t opsum_data_i,
    output int                       tests_done_o,
    output int                       tests_bad_o,
    output int                       errors_o
);

    localparam int NUM_RECORDS  = 3;
    localparam int RECORD_WORDS = 17;
    localparam int EXP_OFFSET   = 13;       // header, 8 weights and 4 vectors come first
    localparam int NUM_VECTORS  = 4;

    accel_mem_pkg::glb_word_t testdata [NUM_RECORDS*RECORD_WORDS];
    logic                     start_q;
    logic                     out_of_reset_q;
    logic                     started;
    logic                     in_run;
    int                       cur_rec;
    int                       opsum_cnt;
    int                       run_errors;
    int                       idle_cycles;

    initial begin
        $readmemh("testbench/conv_core_testdata.mem", testdata);
        tests_done_o = 0;
        tests_bad_o  = 0;
        errors_o     = 0;
        started      = 1'b0;
        in_run       = 1'b0;
        cur_rec      = 0;
        opsum_cnt    = 0;
        run_errors   = 0;
        idle_cycles  = 0;
    end

    function automatic string test_name(input int num);
        case (num)
            1:       test_name = "pointwise full enable";
            2:       test_name = "pointwise partial enable";
            3:       test_name = "conv3x3 clipped enable";
            4:       test_name = "rerun under host contention";
            default: test_name = "layer run";
        endcase
    endfunction

    task automatic note_error(input string msg);
        $display("%s", msg);
        run_errors++;
        errors_o++;
    endtask

    task automatic expect_bit(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            note_error($sformatf("Mismatch at %0t ns: %s expected %b actual %b",
                                 $time, name, expected, actual));
        end
    endtask

    task automatic finish_test(input string name);
        if (run_errors == 0) begin
            $display("test %0d %s: ok", tests_done_o, name);
        end else begin
            $display("test %0d %s: %0d errors", tests_done_o, name, run_errors);
            tests_bad_o++;
        end
        tests_done_o++;
        run_errors = 0;
    endtask

    task automatic check_opsum();
        accel_mem_pkg::glb_word_t expected;
        int                       idx;
        idx = int'(opsum_index_i);
        if (!in_run) begin
            note_error($sformatf("opsum_valid_o at %0t ns with no layer running", $time));
        end else if (idx >= NUM_VECTORS) begin
            note_error($sformatf("opsum index %0d at %0t ns is beyond the last vector", idx, $time));
        end else begin
            if (idx != opsum_cnt) begin // opsums must come in index order
                note_error($sformatf("Mismatch at %0t ns: opsum_index_o expected %0d actual %0d",
                                     $time, opsum_cnt, idx));
            end
            expected = testdata[cur_rec*RECORD_WORDS + EXP_OFFSET + idx];
            for (int r = 0; r < accel_cfg_pkg::ARRAY_DIM; r++) begin
                if (opsum_data_i[r*accel_mem_pkg::LANE_W +: accel_mem_pkg::LANE_W] !==
                    expected[r*accel_mem_pkg::LANE_W +: accel_mem_pkg::LANE_W]) begin
                    note_error($sformatf(
                        "Mismatch at %0t ns: opsum_data_o lane %0d expected %h actual %h (vector %0d)",
                        $time, r, expected[r*accel_mem_pkg::LANE_W +: accel_mem_pkg::LANE_W],
                        opsum_data_i[r*accel_mem_pkg::LANE_W +: accel_mem_pkg::LANE_W], idx));
                end
            end
        end
        opsum_cnt++;
    endtask

    // start and reset are driven on the falling edge, so take them at the rising one
    always @(posedge clk) begin
        start_q        <= start_i;
        out_of_reset_q <= !reset_i;
    end

    always @(negedge clk) begin
        if (start_q) begin
            if (!started) begin
                started = 1'b1;
                finish_test($sformatf("reset state over %0d idle cycles", idle_cycles));
            end else if (in_run) begin
                note_error($sformatf("start_i at %0t ns while a layer was running", $time));
            end
            in_run    = 1'b1;
            cur_rec   = rec_sel_i;
            opsum_cnt = 0;
        end else if (out_of_reset_q && !started) begin
            idle_cycles++;
            expect_bit("busy_o", busy_i, 1'b0);
            expect_bit("done_o", done_i, 1'b0);
            expect_bit("opsum_valid_o", opsum_valid_i, 1'b0);
        end

        if (in_run && !done_i) begin
            expect_bit("busy_o", busy_i, 1'b1); // layer still in progress
        end

        if (opsum_valid_i) begin
            check_opsum();
        end

        if (done_i) begin
            if (!in_run) begin
                note_error($sformatf("extra done_o pulse at %0t ns with no layer running", $time));
            end else begin
                if (opsum_cnt != NUM_VECTORS) begin
                    note_error($sformatf("done_o at %0t ns after %0d opsums instead of %0d",
                                         $time, opsum_cnt, NUM_VECTORS));
                end
                in_run = 1'b0;
                finish_test(test_name(tests_done_o));
            end
        end
    end

endmodule

//--- testbench/conv_core_tb.sv
// convolution core testbench
`timescale 1ns/1ns

module conv_core_tb;

    localparam int          NUM_RECORDS    = 3;
    localparam int          RECORD_WORDS   = 17;
    localparam int          NUM_RUNS       = 4;
    localparam int          TIMEOUT_CYCLES = 4 * NUM_RUNS * (8 + 4 + 17 + 40);
    localparam int unsigned RAND_SEED      = 32'h25882d74;

    logic                       clk;
    logic                       reset;
    logic                       host_wr_en;
    accel_mem_pkg::glb_addr_t   host_addr;
    accel_mem_pkg::glb_word_t   host_wdata;
    logic                       start;
    accel_cfg_pkg::layer_type_e layer_type;
    accel_cfg_pkg::chan_t       ic_real;
    accel_cfg_pkg::chan_t       oc_real;
    accel_cfg_pkg::vec_cnt_t    num_vectors;
    logic                       busy;
    logic                       done;
    logic                       opsum_valid;
    accel_cfg_pkg::vec_idx_t    opsum_index;
    accel_mem_pkg::glb_word_t   opsum_data;
    int                         rec_sel;
    int                         cycle_cnt = 0;
    int                         tests_done;
    int                         tests_bad;
    int                         errors;
    accel_mem_pkg::glb_word_t   testdata [NUM_RECORDS*RECORD_WORDS];

    conv_core_top i_conv_core_top (
        .clk           (clk),
        .reset_i       (reset),
        .host_wr_en_i  (host_wr_en),
        .host_addr_i   (host_addr),
        .host_wdata_i  (host_wdata),
        .start_i       (start),
        .layer_type_i  (layer_type),
        .ic_real_i     (ic_real),
        .oc_real_i     (oc_real),
        .num_vectors_i (num_vectors),
        .busy_o        (busy),
        .done_o        (done),
        .opsum_valid_o (opsum_valid),
        .opsum_index_o (opsum_index),
        .opsum_data_o  (opsum_data)
    );

    conv_core_checker i_conv_core_checker (
        .clk           (clk),
        .reset_i       (reset),
        .start_i       (start),
        .rec_sel_i     (rec_sel),
        .busy_i        (busy),
        .done_i        (done),
        .opsum_valid_i (opsum_valid),
        .opsum_index_i (opsum_index),
        .opsum_data_i  (opsum_data),
        .tests_done_o  (tests_done),
        .tests_bad_o   (tests_bad),
        .errors_o      (errors)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("tests failed");
            $finish;
        end
    end

    task automatic write_word(input accel_mem_pkg::glb_addr_t addr,
                              input accel_mem_pkg::glb_word_t data);
        @(negedge clk);
        host_wr_en = 1'b1;
        host_addr  = addr;
        host_wdata = data;
    endtask

    // done_o is a registered pulse and stable at the falling edge
    task automatic wait_done(input bit contend);
        bit seen;
        seen = 1'b0;
        while (!seen) begin
            @(negedge clk);
            if (done) begin
                seen = 1'b1;
            end
            if (contend && !seen && ($urandom % 2 == 1)) begin
                host_wr_en = 1'b1; // steals the glb port from the sequencer
                host_addr  = accel_mem_pkg::SCRATCH_BASE + accel_mem_pkg::glb_addr_t'($urandom % 16);
                host_wdata = {$urandom, $urandom, $urandom, $urandom};
            end else begin
                host_wr_en = 1'b0;
            end
        end
    endtask

    task automatic run_layer(input int rec, input bit contend);
        accel_mem_pkg::glb_word_t header;
        int                       base;
        base        = rec * RECORD_WORDS;
        header      = testdata[base];
        rec_sel     = rec;
        layer_type  = accel_cfg_pkg::layer_type_e'(header[1:0]);
        ic_real     = header[16 +: 8];
        oc_real     = header[32 +: 8];
        num_vectors = accel_cfg_pkg::vec_cnt_t'(header[48 +: 16]);
        for (int c = 0; c < 8; c++) begin
            write_word(accel_mem_pkg::WEIGHT_BASE + accel_mem_pkg::glb_addr_t'(c),
                       testdata[base + 1 + c]);
        end
        for (int v = 0; v < 4; v++) begin
            write_word(accel_mem_pkg::IFMAP_BASE + accel_mem_pkg::glb_addr_t'(v),
                       testdata[base + 9 + v]);
        end
        @(negedge clk);
        host_wr_en = 1'b0;
        start      = 1'b1;
        @(negedge clk);
        start = 1'b0;
        wait_done(contend);
    endtask

    initial begin
        void'($urandom(RAND_SEED));
        reset       = 1'b1;
        host_wr_en  = 1'b0;
        host_addr   = '0;
        host_wdata  = '0;
        start       = 1'b0;
        layer_type  = accel_cfg_pkg::POINTWISE;
        ic_real     = '0;
        oc_real     = '0;
        num_vectors = '0;
        rec_sel     = 0;
        $readmemh("testbench/conv_core_testdata.mem", testdata);

        repeat (4) @(negedge clk);
        reset = 1'b0;
        repeat (6) @(negedge clk); // idle window for the reset state check

        run_layer(0, 1'b0);
        run_layer(1, 1'b0);
        run_layer(2, 1'b0);
        run_layer(2, 1'b1);
        repeat (4) @(negedge clk); // catches a stray done or opsum

        $display("summary: %0d tests run, %0d with errors, %0d check errors",
                 tests_done, tests_bad, errors);
        if (tests_bad == 0 && errors == 0 && tests_done == NUM_RUNS + 1) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- testbench/conv_core_testdata.mem
// each record is a header, 8 weight words, 4 ifmap words and 4 expected opsum words
// header lane 0 is layer type, lane 1 ic, lane 2 oc, lane 3 vector count
00000000000000000004000800080000
00390031002900210019001100090001
003a0032002a0022001a0012000a0002
003b0033002b0023001b0013000b0003
003c0034002c0024001c0014000c0004
003d0035002d0025001d0015000d0005
003e0036002e0026001e0016000e0006
003f0037002f0027001f0017000f0007
00400038003000280020001800100008
00080007000600050004000300020001
00ff00ff00ff00ff00ff00ff00ff00ff
00010002000300040005000600070008
00200000000000000000000000000010
08ac078c066c054c042c030c01ec00cc
e21ca25c629c22dce31ca35c639c23dc
08580738061804f803d802b801980078
0b900a10089007100590041002900110
00000000000000000004000500030000
00080010001800200028003000380040
0007000f0017001f0027002f0037003f
0006000e0016001e0026002e0036003e
0005000d0015001d0025002d0035003d
0004000c0014001c0024002c0034003c
0003000b0013001b0023002b0033003b
0002000a0012001a0022002a0032003a
00010009001100190021002900310039
00090009000900090009000300020001
00ff00ff00ff00ff00ff003000200010
000500040003000200010000000000ff
00800080008000800080000700000000
00000000000000b800e8011801480178
0000000000000b800e80118014801780
0000000000001fe027d82fd037c83fc0
00000000000000d2010a0142017a01b2
00000000000000000004000400020001
00390031002900210019001100090001
003a0032002a0022001a0012000a0002
003b0033002b0023001b0013000b0003
003c0034002c0024001c0014000c0004
003d0035002d0025001d0015000d0005
003e0036002e0026001e0016000e0006
003f0037002f0027001f0017000f0007
00400038003000280020001800100008
00600050000100010001000100010001
00ff00ff000200000000000000000000
00010001003c00320028001e0014000a
003300000064000000000000000000c8
01650135010500d500a5007500450015
007c006c005c004c003c002c001c000c
317e2aee245e1dce173e10ae0a1e038e
44c03b60320028a01f4015e00c800320
